// File: logic/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// word address, the two low byte bits are not carried
`define BP_ADDR_WIDTH   30

// kind, btb and local history tables
`define BP_INDEX_WIDTH  6

`define BP_LH_WIDTH     4   // local history bits per entry
`define BP_GH_WIDTH     6   // global history length

`define BP_STACK_DEPTH  8

// first fetch address out of reset
`define BP_RESET_PC     30'h0700_0000

`endif

// File: logic/bp_pkg.sv
`include "bp_config.svh"

package bp_pkg;

    // unconditional kinds keep bit 2 set
    typedef enum logic [2:0] {
        kind_none     = 3'd0,
        kind_direct   = 3'd1,   // conditional
        kind_ret      = 3'd4,
        kind_indirect = 3'd5,
        kind_call     = 3'd6,
        kind_jump     = 3'd7
    } branch_kind_e;

    typedef enum logic [1:0] {
        strong_nt,
        weak_nt,
        weak_t,
        strong_t
    } counter_e;

    typedef logic [`BP_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`BP_INDEX_WIDTH-1:0] index_t;

    // xor fold of the whole word address
    function automatic index_t pc_hash(input addr_t pc);
        index_t h;
        h = '0;
        for (int i = 0; i < `BP_ADDR_WIDTH; i += `BP_INDEX_WIDTH) begin
            h ^= index_t'(pc >> i);
        end
        return h;
    endfunction

    // history comes in zero extended, folded down to index width
    function automatic index_t history_hash(input index_t idx, input logic [31:0] hist);
        index_t h;
        h = idx;
        for (int i = 0; i < 32; i += `BP_INDEX_WIDTH) begin
            h ^= index_t'(hist >> i);
        end
        return h;
    endfunction

endpackage

// File: logic/bp_update_if.sv
`timescale 1ns/1ps

// resolved branch from execute, one cycle per update
interface bp_update_if;
    logic                 valid;
    bp_pkg::addr_t        pc;
    bp_pkg::index_t       index;    // pc_hash(pc), computed once at the top
    bp_pkg::branch_kind_e kind;
    logic                 taken;
    bp_pkg::addr_t        target;
    bp_pkg::addr_t        ret_pc;   // return address of a call

    modport sender (
        output valid, pc, index, kind, taken, target, ret_pc
    );

    modport tables (
        input valid, pc, index, kind, taken, target, ret_pc
    );
endinterface

// File: logic/kind_table.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module kind_table (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  bp_pkg::index_t       read_index,
    bp_update_if.tables          upd,
    output bp_pkg::branch_kind_e kind_pdc
);

    localparam int TABLE_SIZE = 1 << `BP_INDEX_WIDTH;

    bp_pkg::branch_kind_e kinds [TABLE_SIZE];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                kinds[i] <= bp_pkg::kind_none;
            end
            kind_pdc <= bp_pkg::kind_none;
        end else begin
            if (upd.valid) begin
                kinds[upd.index] <= upd.kind;   // last resolved kind wins
            end
            if (!stall) begin
                kind_pdc <= kinds[read_index];  // old contents on a same-edge write
            end
        end
    end

    // encodings 2 and 3 must never reach fetch, whatever execute sends
    assert property (@(posedge clk) disable iff (!rstn)
        !(kind_pdc inside {3'd2, 3'd3}));

endmodule

// File: logic/global_history.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module global_history (
    input  logic                    clk,
    input  logic                    rstn,
    bp_update_if.tables             upd,
    output logic [`BP_GH_WIDTH-1:0] history
);

    logic shift_en;

    // every resolved branch shifts, not only conditional ones
    assign shift_en = upd.valid && (upd.kind != bp_pkg::kind_none);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            history <= '0;
        end else if (shift_en) begin
            history <= {history[`BP_GH_WIDTH-2:0], upd.taken}; // newest in bit 0
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        !upd.valid |=> $stable(history));

endmodule

// File: logic/direction_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module direction_predictor (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    stall,
    input  bp_pkg::index_t          read_index,
    input  logic [`BP_GH_WIDTH-1:0] history,
    bp_update_if.tables             upd,
    output logic                    taken_pdc,  // raw direction, kind not applied
    output logic                    choice_pdc  // 1 means gshare was used
);

    localparam int TABLE_SIZE = 1 << `BP_INDEX_WIDTH;

    logic [`BP_LH_WIDTH-1:0] lht [TABLE_SIZE];
    bp_pkg::counter_e        local_ctr [TABLE_SIZE];
    bp_pkg::counter_e        gshare_ctr [TABLE_SIZE];
    bp_pkg::counter_e        chooser [TABLE_SIZE];   // below weak_t favours local

    logic [`BP_LH_WIDTH-1:0] lh_rd;
    logic [`BP_LH_WIDTH-1:0] lh_up;
    bp_pkg::index_t          local_rd_idx;
    bp_pkg::index_t          gshare_rd_idx;
    bp_pkg::index_t          local_up_idx;
    bp_pkg::index_t          gshare_up_idx;
    logic                    local_up_taken;
    logic                    gshare_up_taken;
    logic                    train_en;

    logic local_q;
    logic gshare_q;
    logic choice_q;

    function automatic bp_pkg::counter_e ctr_next(input bp_pkg::counter_e c, input logic up);
        ctr_next = c;
        if (up && c != bp_pkg::strong_t) begin
            ctr_next = bp_pkg::counter_e'(c + 2'd1);
        end else if (!up && c != bp_pkg::strong_nt) begin
            ctr_next = bp_pkg::counter_e'(c - 2'd1);
        end
    endfunction

    // lookup side, two levels on the local path
    assign lh_rd         = lht[read_index];
    assign local_rd_idx  = bp_pkg::history_hash(read_index, 32'(lh_rd));
    assign gshare_rd_idx = bp_pkg::history_hash(read_index, 32'(history));

    // training side sees the state before this update
    assign train_en        = upd.valid && (upd.kind == bp_pkg::kind_direct);
    assign lh_up           = lht[upd.index];
    assign local_up_idx    = bp_pkg::history_hash(upd.index, 32'(lh_up));
    assign gshare_up_idx   = bp_pkg::history_hash(upd.index, 32'(history));
    assign local_up_taken  = local_ctr[local_up_idx][1];    // msb is the direction
    assign gshare_up_taken = gshare_ctr[gshare_up_idx][1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                lht[i]        <= '0;
                local_ctr[i]  <= bp_pkg::weak_nt;
                gshare_ctr[i] <= bp_pkg::weak_nt;
                chooser[i]    <= bp_pkg::weak_nt;
            end
            local_q  <= 1'b0;
            gshare_q <= 1'b0;
            choice_q <= 1'b0;
        end else begin
            if (train_en) begin
                local_ctr[local_up_idx]   <= ctr_next(local_ctr[local_up_idx], upd.taken);
                gshare_ctr[gshare_up_idx] <= ctr_next(gshare_ctr[gshare_up_idx], upd.taken);
                lht[upd.index]            <= {lh_up[`BP_LH_WIDTH-2:0], upd.taken};
                if (local_up_taken != gshare_up_taken) begin
                    // move toward gshare only if gshare got it right
                    chooser[upd.index] <= ctr_next(chooser[upd.index],
                                                   gshare_up_taken == upd.taken);
                end
            end
            if (!stall) begin
                local_q  <= local_ctr[local_rd_idx][1];
                gshare_q <= gshare_ctr[gshare_rd_idx][1];
                choice_q <= chooser[read_index][1];
            end
        end
    end

    assign taken_pdc  = choice_q ? gshare_q : local_q;
    assign choice_pdc = choice_q;

endmodule

// File: logic/target_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module target_predictor (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  bp_pkg::index_t       read_index,
    input  bp_pkg::addr_t        pc_reg,
    input  bp_pkg::branch_kind_e kind_pdc,
    input  logic                 taken_pdc,
    bp_update_if.tables          upd,
    output bp_pkg::addr_t        npc_pdc
);

    localparam int TABLE_SIZE = 1 << `BP_INDEX_WIDTH;
    localparam int PTR_W      = $clog2(`BP_STACK_DEPTH);

    logic          btb_valid [TABLE_SIZE];
    bp_pkg::addr_t btb_tag [TABLE_SIZE];     // full pc, no aliasing
    bp_pkg::addr_t btb_target [TABLE_SIZE];

    bp_pkg::addr_t   stack [`BP_STACK_DEPTH];
    logic [PTR_W:0]  sp;                     // entry count, 0 is empty
    logic [PTR_W-1:0] top_ptr;

    logic          btb_wr;
    logic          push;
    logic          pop;

    logic          btb_valid_q;
    bp_pkg::addr_t btb_tag_q;
    bp_pkg::addr_t btb_target_q;
    logic          ras_valid_q;
    bp_pkg::addr_t ras_top_q;
    logic          btb_hit;

    assign btb_wr  = upd.valid && upd.taken && (upd.kind != bp_pkg::kind_ret)
                     && (upd.kind != bp_pkg::kind_none);
    assign push    = upd.valid && (upd.kind == bp_pkg::kind_call);
    assign pop     = upd.valid && (upd.kind == bp_pkg::kind_ret);
    assign top_ptr = PTR_W'(sp - 1'b1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                btb_valid[i] <= 1'b0;
            end
            btb_valid_q <= 1'b0;
            ras_valid_q <= 1'b0;
        end else begin
            if (btb_wr) begin
                btb_valid[upd.index] <= 1'b1;
            end
            if (!stall) begin
                btb_valid_q <= btb_valid[read_index];
                ras_valid_q <= (sp != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btb_wr) begin
            btb_tag[upd.index]    <= upd.pc;
            btb_target[upd.index] <= upd.target;
        end
        if (push && sp != `BP_STACK_DEPTH) begin
            stack[sp[PTR_W-1:0]] <= upd.ret_pc;
        end
        if (!stall) begin
            btb_tag_q    <= btb_tag[read_index];
            btb_target_q <= btb_target[read_index];
            ras_top_q    <= stack[top_ptr];
        end
    end

    // stack moves only at execute, never speculatively
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sp <= '0;
        end else if (push && sp != `BP_STACK_DEPTH) begin
            sp <= sp + 1'b1;
        end else if (pop && sp != '0) begin
            sp <= sp - 1'b1;
        end
    end

    assign btb_hit = btb_valid_q && (btb_tag_q == pc_reg);

    always_comb begin
        npc_pdc = pc_reg + 1'b1;   // fall through
        if (kind_pdc == bp_pkg::kind_ret) begin
            if (ras_valid_q) begin
                npc_pdc = ras_top_q;
            end
        end else if (taken_pdc && btb_hit) begin
            npc_pdc = btb_target_q;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) pop |-> sp != '0);
    assert property (@(posedge clk) disable iff (!rstn) push |-> sp != `BP_STACK_DEPTH);

endmodule

// File: logic/branch_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  bp_pkg::addr_t        pc,
    input  logic                 update_en,
    input  bp_pkg::addr_t        pc_ex,
    input  bp_pkg::branch_kind_e kind_ex,
    input  logic                 taken_real,
    input  bp_pkg::addr_t        npc_ex,
    input  bp_pkg::addr_t        ret_pc_ex,
    output bp_pkg::addr_t        npc_pdc,
    output bp_pkg::branch_kind_e kind_pdc,
    output logic                 taken_pdc,
    output logic                 choice_pdc
);

    bp_pkg::addr_t           pc_reg;
    bp_pkg::index_t          fetch_index;
    logic [`BP_GH_WIDTH-1:0] history;
    logic                    dir_taken;

    bp_update_if upd ();

    assign fetch_index = bp_pkg::pc_hash(pc);   // tables read at the sampling edge

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= `BP_RESET_PC;
        end else if (!stall) begin
            pc_reg <= pc;
        end
    end

    assign upd.valid  = update_en;
    assign upd.pc     = pc_ex;
    assign upd.index  = bp_pkg::pc_hash(pc_ex);
    assign upd.kind   = kind_ex;
    assign upd.taken  = taken_real;
    assign upd.target = npc_ex;
    assign upd.ret_pc = ret_pc_ex;

    kind_table u_kind_table (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .read_index (fetch_index),
        .upd        (upd),
        .kind_pdc   (kind_pdc)
    );

    global_history u_global_history (
        .clk     (clk),
        .rstn    (rstn),
        .upd     (upd),
        .history (history)
    );

    direction_predictor u_direction_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .read_index (fetch_index),
        .history    (history),
        .upd        (upd),
        .taken_pdc  (dir_taken),
        .choice_pdc (choice_pdc)
    );

    // only conditional branches use the counters
    assign taken_pdc = (kind_pdc == bp_pkg::kind_direct) ? dir_taken
                                                         : (kind_pdc != bp_pkg::kind_none);

    target_predictor u_target_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .read_index (fetch_index),
        .pc_reg     (pc_reg),
        .kind_pdc   (kind_pdc),
        .taken_pdc  (taken_pdc),
        .upd        (upd),
        .npc_pdc    (npc_pdc)
    );

endmodule

// File: test/branch_predictor_tb.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor_tb;

    localparam int MAX_CYCLES = 2000;   // all tests together need well under 200

    logic                 clk;
    logic                 rstn;
    logic                 stall;
    bp_pkg::addr_t        pc;
    logic                 update_en;
    bp_pkg::addr_t        pc_ex;
    bp_pkg::branch_kind_e kind_ex;
    logic                 taken_real;
    bp_pkg::addr_t        npc_ex;
    bp_pkg::addr_t        ret_pc_ex;
    bp_pkg::addr_t        npc_pdc;
    bp_pkg::branch_kind_e kind_pdc;
    logic                 taken_pdc;
    logic                 choice_pdc;

    int errors = 0;
    int errors_at_start = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int cycles = 0;

    bp_pkg::addr_t ras_model [$];   // expected return stack, top at the back

    branch_predictor dut (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .pc         (pc),
        .update_en  (update_en),
        .pc_ex      (pc_ex),
        .kind_ex    (kind_ex),
        .taken_real (taken_real),
        .npc_ex     (npc_ex),
        .ret_pc_ex  (ret_pc_ex),
        .npc_pdc    (npc_pdc),
        .kind_pdc   (kind_pdc),
        .taken_pdc  (taken_pdc),
        .choice_pdc (choice_pdc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // only conditional branches may differ from their kind's fixed direction
    assert property (@(negedge clk) disable iff (!rstn)
        (kind_pdc != bp_pkg::kind_direct) |-> (taken_pdc == (kind_pdc != bp_pkg::kind_none)))
        else begin
            $display("ERROR %0t: kind %0d predicted with taken %0b", $time, kind_pdc, taken_pdc);
            errors++;
        end

    function automatic bp_pkg::addr_t fall_through(input bp_pkg::addr_t p);
        return p + 1'b1;
    endfunction

    function automatic bp_pkg::addr_t ret_target(input bp_pkg::addr_t p);
        if (ras_model.size() == 0) begin
            return fall_through(p);   // empty stack falls through
        end
        return ras_model[$];
    endfunction

    task automatic check_pred(input string what, input bp_pkg::branch_kind_e k,
                              input logic t, input bp_pkg::addr_t n);
        checks++;
        assert (kind_pdc == k && taken_pdc == t && npc_pdc == n) else begin
            $display("ERROR %0t: %s got kind %0d taken %0b npc %h, expected %0d %0b %h",
                     $time, what, kind_pdc, taken_pdc, npc_pdc, k, t, n);
            errors++;
        end
    endtask

    task automatic check_choice(input string what, input logic c);
        checks++;
        assert (choice_pdc == c) else begin
            $display("ERROR %0t: %s got choice %0b, expected %0b", $time, what, choice_pdc, c);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
        errors_at_start = errors;
    endtask

    // called on a falling edge, returns on the next one
    task automatic lookup(input bp_pkg::addr_t p);
        pc = p;
        stall = 1'b0;
        @(negedge clk);
    endtask

    task automatic apply_update(input bp_pkg::addr_t p, input bp_pkg::branch_kind_e k,
                                input logic t, input bp_pkg::addr_t tgt,
                                input bp_pkg::addr_t rpc);
        update_en = 1'b1;
        pc_ex = p;
        kind_ex = k;
        taken_real = t;
        npc_ex = tgt;
        ret_pc_ex = rpc;
        @(negedge clk);
        update_en = 1'b0;
    endtask

    task automatic call_update(input bp_pkg::addr_t p, input bp_pkg::addr_t ret_addr);
        ras_model.push_back(ret_addr);
        apply_update(p, bp_pkg::kind_call, 1'b1, bp_pkg::addr_t'($urandom), ret_addr);
    endtask

    task automatic ret_update(input bp_pkg::addr_t p);
        bp_pkg::addr_t popped;
        popped = ras_model.pop_back();
        apply_update(p, bp_pkg::kind_ret, 1'b1, popped, '0);
    endtask

    initial begin
        bp_pkg::addr_t base;
        bp_pkg::addr_t pc_j;
        bp_pkg::addr_t pc_d;
        bp_pkg::addr_t pc_u;
        bp_pkg::addr_t pc_a;
        bp_pkg::addr_t pc_b;
        bp_pkg::addr_t pc_c;
        bp_pkg::addr_t pc_r;
        bp_pkg::addr_t tgt_j;
        bp_pkg::addr_t tgt_d;
        bp_pkg::addr_t tgt_u;

        rstn = 1'b0;
        stall = 1'b0;
        pc = '0;
        update_en = 1'b0;
        pc_ex = '0;
        kind_ex = bp_pkg::kind_none;
        taken_real = 1'b0;
        npc_ex = '0;
        ret_pc_ex = '0;

        void'($urandom(32'h4a96));
        // the hash is an xor fold, so base ^ k gives a distinct index per k
        base  = bp_pkg::addr_t'($urandom);
        pc_j  = base ^ bp_pkg::addr_t'(1);
        pc_d  = base ^ bp_pkg::addr_t'(2);
        pc_a  = base ^ bp_pkg::addr_t'(3);
        pc_b  = base ^ bp_pkg::addr_t'(4);
        pc_c  = base ^ bp_pkg::addr_t'(5);
        pc_r  = base ^ bp_pkg::addr_t'(6);
        pc_u  = base ^ bp_pkg::addr_t'(7);
        tgt_j = bp_pkg::addr_t'($urandom);
        tgt_d = bp_pkg::addr_t'($urandom);
        tgt_u = bp_pkg::addr_t'($urandom);

        repeat (8) @(negedge clk);
        rstn = 1'b1;

        lookup(base ^ bp_pkg::addr_t'(8));
        check_pred("reset", bp_pkg::kind_none, 1'b0, fall_through(base ^ bp_pkg::addr_t'(8)));
        end_test("reset_state");

        apply_update(pc_j, bp_pkg::kind_jump, 1'b1, tgt_j, '0);
        lookup(pc_j);
        check_pred("jump", bp_pkg::kind_jump, 1'b1, tgt_j);
        end_test("kind_and_btb");

        // enough updates to fill both histories with ones and saturate
        repeat (`BP_GH_WIDTH + 2) apply_update(pc_d, bp_pkg::kind_direct, 1'b1, tgt_d, '0);
        lookup(pc_d);
        check_pred("trained taken", bp_pkg::kind_direct, 1'b1, tgt_d);
        repeat (`BP_GH_WIDTH + 2) begin
            apply_update(pc_d, bp_pkg::kind_direct, 1'b0, fall_through(pc_d), '0);
        end
        lookup(pc_d);
        check_pred("trained not taken", bp_pkg::kind_direct, 1'b0, fall_through(pc_d));
        end_test("direction_training");

        // teach both returns their kind first, leaving the stack empty
        call_update(pc_a, fall_through(pc_a));
        ret_update(pc_c);
        call_update(pc_a, fall_through(pc_a));
        ret_update(pc_r);
        call_update(pc_a, fall_through(pc_a));
        call_update(pc_b, fall_through(pc_b));
        lookup(pc_c);
        check_pred("ret after two calls", bp_pkg::kind_ret, 1'b1, ret_target(pc_c));
        ret_update(pc_c);
        lookup(pc_r);
        check_pred("ret after one pop", bp_pkg::kind_ret, 1'b1, ret_target(pc_r));
        ret_update(pc_r);
        lookup(pc_c);
        check_pred("ret on empty stack", bp_pkg::kind_ret, 1'b1, ret_target(pc_c));
        end_test("return_stack");

        // jumps never train the chooser, so pc_j stays on local
        lookup(pc_j);
        check_pred("before stall", bp_pkg::kind_jump, 1'b1, tgt_j);
        check_choice("before stall", 1'b0);
        stall = 1'b1;
        pc = pc_d;
        apply_update(pc_u, bp_pkg::kind_indirect, 1'b1, tgt_u, '0);   // lands while stalled
        repeat (4) begin
            check_pred("stall hold", bp_pkg::kind_jump, 1'b1, tgt_j);
            check_choice("stall hold", 1'b0);
            @(negedge clk);
        end
        lookup(pc_d);
        check_pred("after stall", bp_pkg::kind_direct, 1'b0, fall_through(pc_d));
        lookup(pc_u);
        check_pred("update during stall", bp_pkg::kind_indirect, 1'b1, tgt_u);
        end_test("stall_hold");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
+incdir+logic
logic/bp_pkg.sv
logic/bp_update_if.sv
logic/kind_table.sv
logic/global_history.sv
logic/direction_predictor.sv
logic/target_predictor.sv
logic/branch_predictor.sv
test/branch_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f branch_predictor.f \
    -o sim_branch_predictor

# a run stopped by an assertion still leaves its log for the search below
./obj_dir/sim_branch_predictor > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    exit 1
fi
exit 0
